//--- project.f
hw/ctrl_pkg.sv
hw/instr_decoder.sv
hw/control_sequencer.sv
hw/control_unit.sv
tb/control_sequencer_asserts.sv
tb/ctrl_checker.sv
tb/tb_control_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_control_unit \
	-f project.f \
	-o sim_control_unit \
	|| { echo "build failed"; exit 1; }

output="$(./obj_dir/sim_control_unit)"
echo "$output"

echo "$output" | grep -qx "sim passed" && exit 0 || exit 1

//--- tb/tb_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit;

	import ctrl_pkg::*;

	localparam int DRAIN_CYCLES = 5;
	localparam int MEM_LAT = 2;
	localparam int NUM_CYCLES = 4000;
	localparam int IDLE_TIMEOUT = 64;

	logic clk;
	logic reset;
	logic interrupt;
	instr_t instruction;
	ctrl_word_t ctrl;
	logic model_idle;
	int error_count;
	int timeout_count;
	int assert_fails;
	int waited;
	int seed;

	control_unit
	#(
		.DRAIN_CYCLES (DRAIN_CYCLES),
		.MEM_LAT      (MEM_LAT)
	)
	i_control_unit
	(
		.clk         (clk),
		.reset       (reset),
		.interrupt   (interrupt),
		.instruction (instruction),
		.ctrl        (ctrl)
	);

	ctrl_checker
	#(
		.DRAIN_CYCLES (DRAIN_CYCLES),
		.MEM_LAT      (MEM_LAT)
	)
	i_ctrl_checker
	(
		.clk         (clk),
		.reset       (reset),
		.interrupt   (interrupt),
		.instruction (instruction),
		.ctrl        (ctrl),
		.model_idle  (model_idle),
		.error_count (error_count)
	);

	bind control_sequencer control_sequencer_asserts
	#(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	)
	i_seq_asserts
	(
		.clk       (clk),
		.reset     (reset),
		.interrupt (interrupt),
		.ctrl      (ctrl),
		.seq_state (state)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// new word only between sequences, interrupt level any cycle
	task automatic drive_random_step();
		logic [31:0] rnd;
		if (model_idle)
		begin
			rnd = $random(seed);
			instruction = rnd[15:0];
		end
		rnd = $random(seed);
		interrupt = ((rnd & 32'd31) == 32'd0);
	endtask

	initial
	begin
		seed = 32'h2a57_dc40;
		timeout_count = 0;
		reset = 1'b0;
		interrupt = 1'b0;
		instruction = '0;
		repeat (5) @(negedge clk);
		reset = 1'b1;

		for (int n = 0; n < NUM_CYCLES; n++)
		begin
			@(negedge clk);
			drive_random_step();
		end

		// let the running sequence finish, then park on a NOP
		waited = 0;
		@(negedge clk);
		interrupt = 1'b0;
		while (!model_idle && waited < IDLE_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!model_idle)
		begin
			$display("timeout: sequence still running after %0d cycles", IDLE_TIMEOUT);
			timeout_count++;
		end
		instruction = 16'h4000;
		@(negedge clk);

		assert_fails = i_control_unit.i_control_sequencer.i_seq_asserts.fail_count;
		$display("errors: %0d, timeouts: %0d, assertion failures: %0d",
			error_count, timeout_count, assert_fails);
		if (error_count == 0 && timeout_count == 0 && assert_fails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_checker
#(
	parameter int DRAIN_CYCLES = 5,
	parameter int MEM_LAT = 2
)
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 interrupt,
	input  ctrl_pkg::instr_t     instruction,
	input  ctrl_pkg::ctrl_word_t ctrl,
	output logic                 model_idle,
	output int                   error_count
);

	import ctrl_pkg::*;

	typedef enum int
	{
		M_IDLE,
		M_CALL_LO,
		M_POP_LO,
		M_POP_HI,
		M_WAIT,
		M_DRAIN,
		M_PUSH_HI,
		M_PUSH_LO,
		M_PUSH_FLAGS
	} model_state_t;

	model_state_t mstate;
	int remaining;
	ctrl_word_t expected;

	assign model_idle = (mstate == M_IDLE);

	function automatic ctrl_word_t nop_word();
		ctrl_word_t w;
		w = '0;
		w.fetch.pc_write = 1'b1;
		w.exec.alu_op = ALU_NONE;
		w.exec.alu_src1 = 2'd2;
		w.wb.wb_sel = WB_ALU;
		return w;
	endfunction

	function automatic ctrl_word_t bubble_model();
		ctrl_word_t w;
		w = nop_word();
		w.fetch.clear_instr = 1'b1;
		w.fetch.pc_write = 1'b0;
		return w;
	endfunction

	function automatic ctrl_word_t apply_push(input ctrl_word_t base, input mem_src_t src);
		ctrl_word_t w;
		w = base;
		w.mem.write = 1'b1;
		w.mem.push = 1'b1;
		w.mem.addr_sel = ADDR_SP;
		w.mem.src_sel = src;
		return w;
	endfunction

	function automatic ctrl_word_t apply_pop(input ctrl_word_t base);
		ctrl_word_t w;
		w = base;
		w.mem.read = 1'b1;
		w.mem.pop = 1'b1;
		w.mem.addr_sel = ADDR_SP;
		w.wb.wb_sel = WB_MEM;
		w.fetch.pc_write = 1'b0;
		return w;
	endfunction

	// reference decode table
	function automatic ctrl_word_t decode_model(input instr_t ins);
		ctrl_word_t w;
		logic [2:0] f;
		logic [2:0] kind;
		w = nop_word();
		f = ins.alu.func;
		kind = ins.br.kind;
		if (ins.alu.cls == CLASS_R)
		begin
			w.exec.flag_en = 1'b1;
			w.wb.reg_write = 1'b1;
			if (f == 3'd0)
				w.exec.alu_op = ALU_NOT;
			else if (f == 3'd1)
				w.exec.alu_op = ins.alu.spare[4] ? ALU_DEC : ALU_INC;
			else
				w.exec.alu_op = alu_op_t'({1'b0, f} + 4'd1);
		end
		else if (ins.alu.cls == CLASS_ONE)
		begin
			case (f)
				3'd1:
				begin
					w.exec.carry_sel = CARRY_SET;
					w.exec.flag_en = 1'b1;
				end
				3'd2:
				begin
					w.exec.carry_sel = CARRY_CLR;
					w.exec.flag_en = 1'b1;
				end
				3'd3:
					w.wb.out_en = 1'b1;
				3'd4:
				begin
					w.fetch.inport_sel = 1'b1;
					w.wb.reg_write = 1'b1;
				end
				3'd5:
					w = apply_push(w, SRC_REG);
				3'd6:
				begin
					w.mem.read = 1'b1;
					w.mem.pop = 1'b1;
					w.mem.addr_sel = ADDR_SP;
					w.wb.reg_write = 1'b1;
					w.wb.wb_sel = WB_MEM;
				end
				default:;
			endcase
		end
		else if (ins.alu.cls == CLASS_TWO)
		begin
			if (f == 3'd0)
				w.wb.reg_write = 1'b1;
			else if (f == 3'd1)
			begin
				w.fetch.clear_instr = 1'b1;
				w.wb.reg_write = 1'b1;
				w.wb.wb_sel = WB_IMM;
			end
			else if (f == 3'd2)
			begin
				w.mem.read = 1'b1;
				w.mem.addr_sel = ADDR_RSRC;
				w.wb.reg_write = 1'b1;
				w.wb.wb_sel = WB_MEM;
			end
		end
		else if (kind < 3'd4)
			w.exec.jump_sel = jump_sel_t'(3'd4 + kind);
		else if (kind == 3'd4)
			w.exec.jump_sel = JUMP_JMP;
		return w;
	endfunction

	function automatic ctrl_word_t expected_word(input model_state_t st, input int rem,
		input logic irq, input instr_t ins);
		ctrl_word_t w;
		logic br;
		br = (ins.br.cls == CLASS_BRANCH);
		w = nop_word();
		case (st)
			M_IDLE:
			begin
				if (irq)
					w = bubble_model();
				else if (br && ins.br.kind == BR_CALL)
					w = apply_push(decode_model(ins), SRC_PC_HI);
				else if (br && ins.br.kind == BR_RET)
					w = apply_pop(decode_model(ins));
				else if (br && ins.br.kind == BR_RETI)
				begin
					w = apply_pop(decode_model(ins));
					w.exec.flag_sel = 1'b1;
					w.exec.flag_en = 1'b1;
				end
				else
					w = decode_model(ins);
			end
			M_CALL_LO:
			begin
				w = apply_push(w, SRC_PC_LO);
				w.fetch.pc_write = 1'b0;
				w.fetch.clear_instr = 1'b1;
			end
			M_POP_LO, M_POP_HI:
				w = apply_pop(w);
			M_WAIT:
			begin
				w = bubble_model();
				// last wait cycle loads the PC
				if (rem == 1)
				begin
					w.fetch.pc_from_mem = 1'b1;
					w.fetch.pc_write = 1'b1;
				end
			end
			M_DRAIN:
				w = bubble_model();
			M_PUSH_HI:
			begin
				w = apply_push(w, SRC_PC_HI);
				w.fetch.pc_write = 1'b0;
			end
			M_PUSH_LO:
			begin
				w = apply_push(w, SRC_PC_LO);
				w.fetch.pc_write = 1'b0;
			end
			default:
			begin
				w = apply_push(w, SRC_FLAGS);
				w.fetch.pc_write = 1'b0;
			end
		endcase
		return w;
	endfunction

	task automatic check_group(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val)
		begin
			error_count++;
			$display("Fail %s expected %h got %h at %0t", name, exp_val, act_val, $time);
		end
	endtask

	always @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			mstate <= M_IDLE;
			remaining <= 0;
			error_count = 0;
		end
		else
		begin
			expected = expected_word(mstate, remaining, interrupt, instruction);
			check_group("ctrl.fetch", 32'(expected.fetch), 32'(ctrl.fetch));
			check_group("ctrl.exec", 32'(expected.exec), 32'(ctrl.exec));
			check_group("ctrl.mem", 32'(expected.mem), 32'(ctrl.mem));
			check_group("ctrl.wb", 32'(expected.wb), 32'(ctrl.wb));

			case (mstate)
				M_IDLE:
				begin
					if (interrupt)
					begin
						mstate <= M_DRAIN;
						remaining <= DRAIN_CYCLES;
					end
					else if (instruction.br.cls == CLASS_BRANCH)
					begin
						if (instruction.br.kind == BR_CALL)
							mstate <= M_CALL_LO;
						else if (instruction.br.kind == BR_RET)
							mstate <= M_POP_HI;
						else if (instruction.br.kind == BR_RETI)
							mstate <= M_POP_LO;
					end
				end
				M_CALL_LO:
					mstate <= M_IDLE;
				M_POP_LO:
					mstate <= M_POP_HI;
				M_POP_HI:
				begin
					mstate <= M_WAIT;
					remaining <= MEM_LAT;
				end
				M_WAIT:
				begin
					if (remaining == 1)
						mstate <= M_IDLE;
					else
						remaining <= remaining - 1;
				end
				M_DRAIN:
				begin
					if (remaining == 1)
						mstate <= M_PUSH_HI;
					else
						remaining <= remaining - 1;
				end
				M_PUSH_HI:
					mstate <= M_PUSH_LO;
				M_PUSH_LO:
					mstate <= M_PUSH_FLAGS;
				default:
					mstate <= M_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tb/control_sequencer_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module control_sequencer_asserts
#(
	parameter int DRAIN_CYCLES = 5
)
(
	input logic                 clk,
	input logic                 reset,
	input logic                 interrupt,
	input ctrl_pkg::ctrl_word_t ctrl,
	input logic [3:0]           seq_state
);

	import ctrl_pkg::*;

	// IDLE is the first state code of the sequencer
	localparam logic [3:0] IDLE_CODE = 4'd0;

	int fail_count = 0;

	push_pop_exclusive: assert property (@(posedge clk) disable iff (!reset)
		!(ctrl.mem.push && ctrl.mem.pop))
	else
	begin
		fail_count++;
		$error("push and pop set in the same cycle");
	end

	pc_from_mem_writes_pc: assert property (@(posedge clk) disable iff (!reset)
		ctrl.fetch.pc_from_mem |-> ctrl.fetch.pc_write)
	else
	begin
		fail_count++;
		$error("pc_from_mem set without pc_write");
	end

	// bubble cycle plus the drain, then the first push
	irq_push_hi_timing: assert property (@(posedge clk) disable iff (!reset)
		(seq_state == IDLE_CODE && interrupt) |-> ##(DRAIN_CYCLES + 1)
		(ctrl.mem.push && ctrl.mem.src_sel == SRC_PC_HI))
	else
	begin
		fail_count++;
		$error("interrupt not followed by a PC_HI push after the drain");
	end

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit
#(
	parameter int DRAIN_CYCLES = 5,
	parameter int MEM_LAT = 2
)
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 interrupt,
	input  ctrl_pkg::instr_t     instruction,
	output ctrl_pkg::ctrl_word_t ctrl
);

	import ctrl_pkg::*;

	// single-cycle decode result
	ctrl_word_t decoded;

	instr_decoder i_instr_decoder
	(
		.instruction (instruction),
		.decoded     (decoded)
	);

	// stack sequences override the decode
	control_sequencer
	#(
		.DRAIN_CYCLES (DRAIN_CYCLES),
		.MEM_LAT      (MEM_LAT)
	)
	i_control_sequencer
	(
		.clk         (clk),
		.reset       (reset),
		.interrupt   (interrupt),
		.instruction (instruction),
		.decoded     (decoded),
		.ctrl        (ctrl)
	);

endmodule

`default_nettype wire

//--- hw/control_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module control_sequencer
#(
	parameter int DRAIN_CYCLES = 5,
	parameter int MEM_LAT = 2
)
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 interrupt,
	input  ctrl_pkg::instr_t     instruction,
	input  ctrl_pkg::ctrl_word_t decoded,
	output ctrl_pkg::ctrl_word_t ctrl
);

	import ctrl_pkg::*;

	localparam int CNT_MAX = (DRAIN_CYCLES > MEM_LAT) ? DRAIN_CYCLES : MEM_LAT;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [3:0]
	{
		IDLE,
		CALL_PUSH_LO,
		POP_PC_LO,
		POP_PC_HI,
		PC_LOAD_WAIT,
		IRQ_DRAIN,
		IRQ_PUSH_HI,
		IRQ_PUSH_LO,
		IRQ_PUSH_FLAGS
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_next;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;
	logic is_branch;

	assign is_branch = (instruction.br.cls == CLASS_BRANCH);

	// stack push on top of a base word
	function automatic ctrl_word_t push_word(input ctrl_word_t base, input mem_src_t src);
		ctrl_word_t w;
		w = base;
		w.mem.push = 1'b1;
		w.mem.write = 1'b1;
		w.mem.addr_sel = ADDR_SP;
		w.mem.src_sel = src;
		return w;
	endfunction

	// stack pop, fetch held
	function automatic ctrl_word_t pop_word(input ctrl_word_t base);
		ctrl_word_t w;
		w = base;
		w.mem.pop = 1'b1;
		w.mem.read = 1'b1;
		w.mem.addr_sel = ADDR_SP;
		w.wb.wb_sel = WB_MEM;
		w.fetch.pc_write = 1'b0;
		return w;
	endfunction

	function automatic ctrl_word_t bubble_word();
		ctrl_word_t w;
		w = default_ctrl;
		w.fetch.clear_instr = 1'b1;
		w.fetch.pc_write = 1'b0;
		return w;
	endfunction

	// next state and counter
	always_comb
	begin
		state_next = state;
		cnt_next = cnt;

		case (state)
			IDLE:
			begin
				if (interrupt)
				begin
					state_next = IRQ_DRAIN;
					cnt_next = CNT_W'(DRAIN_CYCLES - 1);
				end
				else if (is_branch)
				begin
					case (instruction.br.kind)
						BR_CALL: state_next = CALL_PUSH_LO;
						BR_RET:  state_next = POP_PC_HI;
						BR_RETI: state_next = POP_PC_LO;
						default: state_next = IDLE;
					endcase
				end
			end
			CALL_PUSH_LO:
			begin
				state_next = IDLE;
			end
			POP_PC_LO:
			begin
				state_next = POP_PC_HI;
			end
			POP_PC_HI:
			begin
				state_next = PC_LOAD_WAIT;
				cnt_next = CNT_W'(MEM_LAT - 1);
			end
			PC_LOAD_WAIT:
			begin
				if (cnt == '0)
					state_next = IDLE;
				else
					cnt_next = cnt - 1'b1;
			end
			IRQ_DRAIN:
			begin
				if (cnt == '0)
					state_next = IRQ_PUSH_HI;
				else
					cnt_next = cnt - 1'b1;
			end
			IRQ_PUSH_HI:
			begin
				state_next = IRQ_PUSH_LO;
			end
			IRQ_PUSH_LO:
			begin
				state_next = IRQ_PUSH_FLAGS;
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= IDLE;
			cnt <= '0;
		end
		else
		begin
			state <= state_next;
			cnt <= cnt_next;
		end
	end

	// control word out
	always_comb
	begin
		ctrl = default_ctrl;

		case (state)
			IDLE:
			begin
				if (interrupt)
					ctrl = bubble_word();
				else if (is_branch && instruction.br.kind == BR_CALL)
					ctrl = push_word(decoded, SRC_PC_HI);
				else if (is_branch && instruction.br.kind == BR_RET)
					ctrl = pop_word(decoded);
				else if (is_branch && instruction.br.kind == BR_RETI)
				begin
					// flags come off the stack first
					ctrl = pop_word(decoded);
					ctrl.exec.flag_sel = 1'b1;
					ctrl.exec.flag_en = 1'b1;
				end
				else
					ctrl = decoded;
			end
			CALL_PUSH_LO:
			begin
				ctrl = push_word(default_ctrl, SRC_PC_LO);
				ctrl.fetch.pc_write = 1'b0;
				ctrl.fetch.clear_instr = 1'b1;
			end
			POP_PC_LO, POP_PC_HI:
			begin
				ctrl = pop_word(default_ctrl);
			end
			PC_LOAD_WAIT:
			begin
				ctrl = bubble_word();
				// popped PC is valid on the last wait cycle
				if (cnt == '0)
				begin
					ctrl.fetch.pc_from_mem = 1'b1;
					ctrl.fetch.pc_write = 1'b1;
				end
			end
			IRQ_DRAIN:
			begin
				ctrl = bubble_word();
			end
			IRQ_PUSH_HI:
			begin
				ctrl = push_word(default_ctrl, SRC_PC_HI);
				ctrl.fetch.pc_write = 1'b0;
			end
			IRQ_PUSH_LO:
			begin
				ctrl = push_word(default_ctrl, SRC_PC_LO);
				ctrl.fetch.pc_write = 1'b0;
			end
			default:
			begin
				ctrl = push_word(default_ctrl, SRC_FLAGS);
				ctrl.fetch.pc_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
(
	input  ctrl_pkg::instr_t     instruction,
	output ctrl_pkg::ctrl_word_t decoded
);

	import ctrl_pkg::*;

	always_comb
	begin
		// anything not listed below stays a NOP
		decoded = default_ctrl;

		case (instruction.alu.cls)
			CLASS_R:
			begin
				decoded.exec.flag_en = 1'b1;
				decoded.wb.reg_write = 1'b1;
				decoded.wb.wb_sel = WB_ALU;
				case (instruction.alu.func)
					3'd0:
					begin
						decoded.exec.alu_op = ALU_NOT;
					end
					3'd1:
					begin
						// inc and dec share one func code
						if (instruction.alu.spare[4])
							decoded.exec.alu_op = ALU_DEC;
						else
							decoded.exec.alu_op = ALU_INC;
					end
					3'd2:
					begin
						decoded.exec.alu_op = ALU_ADD;
					end
					3'd3:
					begin
						decoded.exec.alu_op = ALU_SUB;
					end
					3'd4:
					begin
						decoded.exec.alu_op = ALU_AND;
					end
					3'd5:
					begin
						decoded.exec.alu_op = ALU_OR;
					end
					3'd6:
					begin
						decoded.exec.alu_op = ALU_SHL;
					end
					default:
					begin
						decoded.exec.alu_op = ALU_SHR;
					end
				endcase
			end

			CLASS_ONE:
			begin
				case (instruction.alu.func)
					// setc
					3'd1:
					begin
						decoded.exec.carry_sel = CARRY_SET;
						decoded.exec.flag_en = 1'b1;
					end
					// clrc
					3'd2:
					begin
						decoded.exec.carry_sel = CARRY_CLR;
						decoded.exec.flag_en = 1'b1;
					end
					// out
					3'd3:
					begin
						decoded.wb.out_en = 1'b1;
					end
					// in
					3'd4:
					begin
						decoded.fetch.inport_sel = 1'b1;
						decoded.wb.reg_write = 1'b1;
					end
					// push rdst
					3'd5:
					begin
						decoded.mem.write = 1'b1;
						decoded.mem.push = 1'b1;
						decoded.mem.addr_sel = ADDR_SP;
						decoded.mem.src_sel = SRC_REG;
					end
					// pop rdst
					3'd6:
					begin
						decoded.mem.read = 1'b1;
						decoded.mem.pop = 1'b1;
						decoded.mem.addr_sel = ADDR_SP;
						decoded.wb.reg_write = 1'b1;
						decoded.wb.wb_sel = WB_MEM;
					end
					default:;
				endcase
			end

			CLASS_TWO:
			begin
				case (instruction.alu.func)
					// mov
					3'd0:
					begin
						decoded.wb.reg_write = 1'b1;
					end
					// ldm, immediate is the next fetched word
					3'd1:
					begin
						decoded.fetch.clear_instr = 1'b1;
						decoded.wb.reg_write = 1'b1;
						decoded.wb.wb_sel = WB_IMM;
					end
					// ldd
					3'd2:
					begin
						decoded.mem.read = 1'b1;
						decoded.mem.addr_sel = ADDR_RSRC;
						decoded.wb.reg_write = 1'b1;
						decoded.wb.wb_sel = WB_MEM;
					end
					default:;
				endcase
			end

			default:
			begin
				case (instruction.br.kind)
					BR_JZ, BR_JN, BR_JC, BR_JMP:
					begin
						decoded.exec.jump_sel = jump_sel_t'({1'b1, instruction.br.kind[1:0]});
					end
					// the stack pushes come from the sequencer
					BR_CALL:
					begin
						decoded.exec.jump_sel = JUMP_JMP;
					end
					default:;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// top two bits of every instruction word
	typedef enum logic [1:0]
	{
		CLASS_R      = 2'd0,
		CLASS_ONE    = 2'd1,
		CLASS_TWO    = 2'd2,
		CLASS_BRANCH = 2'd3
	} instr_class_t;

	typedef enum logic [2:0]
	{
		BR_JZ   = 3'd0,
		BR_JN   = 3'd1,
		BR_JC   = 3'd2,
		BR_JMP  = 3'd3,
		BR_CALL = 3'd4,
		BR_RET  = 3'd5,
		BR_RETI = 3'd6
	} branch_kind_t;

	// spare[4] sits right after func, it picks DEC over INC
	typedef struct packed
	{
		instr_class_t cls;
		logic [2:0]   func;
		logic [4:0]   spare;
		logic [2:0]   rdst;
		logic [2:0]   rsrc;
	} alu_fmt_t;

	typedef struct packed
	{
		instr_class_t cls;
		branch_kind_t kind;
		logic [10:0]  spare;
	} branch_fmt_t;

	// the class field lines up in both views
	typedef union packed
	{
		alu_fmt_t    alu;
		branch_fmt_t br;
	} instr_t;

	typedef enum logic [3:0]
	{
		ALU_NOT  = 4'd0,
		ALU_INC  = 4'd1,
		ALU_DEC  = 4'd2,
		ALU_ADD  = 4'd3,
		ALU_SUB  = 4'd4,
		ALU_AND  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_SHL  = 4'd7,
		ALU_SHR  = 4'd8,
		ALU_NONE = 4'd15
	} alu_op_t;

	// jump codes are 4 plus the branch condition
	typedef enum logic [2:0]
	{
		JUMP_NONE = 3'd0,
		JUMP_JZ   = 3'd4,
		JUMP_JN   = 3'd5,
		JUMP_JC   = 3'd6,
		JUMP_JMP  = 3'd7
	} jump_sel_t;

	typedef enum logic [1:0]
	{
		CARRY_ALU = 2'd0,
		CARRY_SET = 2'd1,
		CARRY_CLR = 2'd2
	} carry_sel_t;

	// data written to the stack or memory
	typedef enum logic [1:0]
	{
		SRC_FLAGS = 2'd0,
		SRC_PC_HI = 2'd1,
		SRC_PC_LO = 2'd2,
		SRC_REG   = 2'd3
	} mem_src_t;

	typedef enum logic [1:0]
	{
		ADDR_NONE = 2'd0,
		ADDR_RSRC = 2'd1,
		ADDR_SP   = 2'd2
	} mem_addr_t;

	typedef enum logic [1:0]
	{
		WB_IMM = 2'd0,
		WB_MEM = 2'd1,
		WB_ALU = 2'd2
	} wb_sel_t;

	typedef struct packed
	{
		logic pc_write;
		logic inport_sel;
		logic clear_instr;
		logic pc_from_mem;
		logic spare;
	} fetch_ctrl_t;

	typedef struct packed
	{
		alu_op_t    alu_op;
		logic [1:0] alu_src1;
		logic [1:0] alu_src2;
		jump_sel_t  jump_sel;
		carry_sel_t carry_sel;
		logic       flag_sel;
		logic       flag_en;
	} exec_ctrl_t;

	typedef struct packed
	{
		logic      read;
		logic      write;
		logic      push;
		logic      pop;
		mem_addr_t addr_sel;
		mem_src_t  src_sel;
	} mem_ctrl_t;

	typedef struct packed
	{
		logic    reg_write;
		wb_sel_t wb_sel;
		logic    out_en;
	} wb_ctrl_t;

	typedef struct packed
	{
		fetch_ctrl_t fetch;
		exec_ctrl_t  exec;
		mem_ctrl_t   mem;
		wb_ctrl_t    wb;
	} ctrl_word_t;

	// NOP control word
	localparam ctrl_word_t default_ctrl = '{
		fetch: '{pc_write: 1'b1, inport_sel: 1'b0, clear_instr: 1'b0,
			pc_from_mem: 1'b0, spare: 1'b0},
		exec: '{alu_op: ALU_NONE, alu_src1: 2'd2, alu_src2: 2'd0,
			jump_sel: JUMP_NONE, carry_sel: CARRY_ALU, flag_sel: 1'b0, flag_en: 1'b0},
		mem: '{read: 1'b0, write: 1'b0, push: 1'b0, pop: 1'b0,
			addr_sel: ADDR_NONE, src_sel: SRC_FLAGS},
		wb: '{reg_write: 1'b0, wb_sel: WB_ALU, out_en: 1'b0}
	};

endpackage

`default_nettype wire
